//--- bench/lsu_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_asserts (
    input wire                  clk,
    input wire                  arst_n,
    input wire                  req,
    input wire ls_pkg::ls_op_e  op,
    input wire                  kill,
    input wire                  addr_err,
    input wire                  rsp_valid,
    input wire                  fault
);

    logic load_go;

    assign load_go = req & ~kill & ~addr_err & ~ls_pkg::is_store(op);  // Accepted load.

    a_rsp_fault_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(rsp_valid && fault))
        else $error("rsp_valid and fault high in the same cycle");

    // A killed request leaves no trace one cycle later.
    a_kill_no_effect: assert property (@(posedge clk) disable iff (!arst_n)
        req && kill |=> !rsp_valid && !fault)
        else $error("response or fault after a killed request");

    // Response exactly one cycle after an accepted load.
    a_load_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        load_go |=> rsp_valid)
        else $error("rsp_valid missing one cycle after a load");

endmodule

`default_nettype wire

//--- bench/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;

    localparam int ADDR_W      = 8;
    localparam int FAULT_CNT_W = 8;
    localparam int DEPTH       = 2 ** ADDR_W;
    localparam int N_MERGE     = 300;
    localparam int N_LOAD      = 300;
    localparam int N_FAULT     = 300;
    localparam int N_KILL      = 100;
    localparam int N_MIX       = 1000;
    localparam int TOTAL_REQ   = 4 * DEPTH + 2 * N_MERGE + N_LOAD + N_FAULT + N_KILL + N_MIX + 16;
    localparam int WATCHDOG_NS = TOTAL_REQ * 8 * 4;
    localparam logic [31:0] SEED = 32'd7205;

    logic                     clk;
    logic                     arst_n;
    logic                     req;
    ls_pkg::ls_op_e           op;
    logic [31:0]              addr;
    logic [31:0]              rt_data;
    logic                     kill;
    logic                     fault_clr;
    logic                     rsp_valid;
    logic [31:0]              rsp_data;
    logic                     fault;
    logic [31:0]              bad_addr;
    logic [FAULT_CNT_W-1:0]   fault_cnt;

    // Reference model state.
    logic [7:0]               mem_m [4*DEPTH];
    logic                     exp_valid;
    logic [31:0]              exp_data;
    logic                     exp_fault;
    logic [31:0]              exp_bad;
    logic [FAULT_CNT_W-1:0]   exp_cnt;
    logic [31:0]              lfsr;
    int                       errors;
    int                       tests_run;
    int                       tests_failed;

    lsu_top #(
        .ADDR_W      (ADDR_W),
        .FAULT_CNT_W (FAULT_CNT_W)
    ) dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .rt_data     (rt_data),
        .kill        (kill),
        .fault_clr   (fault_clr),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .fault       (fault),
        .bad_addr    (bad_addr),
        .fault_cnt   (fault_cnt)
    );

    bind lsu_top lsu_asserts u_asserts (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .op          (op),
        .kill        (kill),
        .addr_err    (addr_err),
        .rsp_valid   (rsp_valid),
        .fault       (fault)
    );

    always #4 clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1.
    function automatic logic lfsr_step();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic bad_align(input ls_pkg::ls_op_e o, input logic [1:0] lo);
        logic bad;
        bad = 1'b0;
        if (o == ls_pkg::LS_LH || o == ls_pkg::LS_LHU || o == ls_pkg::LS_SH) begin
            bad = lo[0];
        end else if (o == ls_pkg::LS_LW || o == ls_pkg::LS_SW) begin
            bad = (lo != 2'b00);
        end
        return bad;
    endfunction

    task automatic model_store(input ls_pkg::ls_op_e o, input logic [31:0] a,
                               input logic [31:0] d);
        int base;
        int lo;
        int h;
        base = int'(a[ADDR_W+1:2]) * 4;
        lo   = int'(a[1:0]);
        h    = a[1] ? 2 : 0;
        case (o)
            ls_pkg::LS_SB: mem_m[base + lo] = d[7:0];
            ls_pkg::LS_SH: begin
                mem_m[base + h]     = d[7:0];
                mem_m[base + h + 1] = d[15:8];
            end
            ls_pkg::LS_SWL: begin
                for (int j = 0; j <= lo; j++) begin
                    mem_m[base + j] = d[8*(3-lo+j) +: 8];     // Top of rt first.
                end
            end
            ls_pkg::LS_SWR: begin
                for (int j = lo; j < 4; j++) begin
                    mem_m[base + j] = d[8*(j-lo) +: 8];
                end
            end
            default: begin
                for (int j = 0; j < 4; j++) begin
                    mem_m[base + j] = d[8*j +: 8];
                end
            end
        endcase
    endtask

    function automatic logic [31:0] model_load(input ls_pkg::ls_op_e o, input logic [31:0] a,
                                               input logic [31:0] d);
        int          base;
        int          lo;
        int          h;
        logic [7:0]  b;
        logic [15:0] hw;
        logic [31:0] res;
        base = int'(a[ADDR_W+1:2]) * 4;
        lo   = int'(a[1:0]);
        h    = a[1] ? 2 : 0;
        b    = mem_m[base + lo];
        hw   = {mem_m[base + h + 1], mem_m[base + h]};
        res  = d;
        case (o)
            ls_pkg::LS_LB:  res = {{24{b[7]}}, b};
            ls_pkg::LS_LBU: res = {24'b0, b};
            ls_pkg::LS_LH:  res = {{16{hw[15]}}, hw};
            ls_pkg::LS_LHU: res = {16'b0, hw};
            ls_pkg::LS_LWL: begin
                for (int j = 0; j <= lo; j++) begin
                    res[8*(3-lo+j) +: 8] = mem_m[base + j];
                end
            end
            ls_pkg::LS_LWR: begin
                for (int j = lo; j < 4; j++) begin
                    res[8*(j-lo) +: 8] = mem_m[base + j];
                end
            end
            default: res = {mem_m[base + 3], mem_m[base + 2], mem_m[base + 1], mem_m[base]};
        endcase
        return res;
    endfunction

    task automatic check_data(input string name, input logic [ls_pkg::DATA_W-1:0] exp,
                              input logic [ls_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_cnt(input string name, input logic [FAULT_CNT_W-1:0] exp,
                             input logic [FAULT_CNT_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp && act !== 1'b1) begin
            $display("%s strobe missing at %0t", name, $time);
            errors++;
        end else if (!exp && act !== 1'b0) begin
            $display("unexpected %s strobe at %0t", name, $time);
            errors++;
        end
    endtask

    // One cycle: check the previous request, then drive and predict the next.
    task automatic drive(input logic r, input ls_pkg::ls_op_e o, input logic [31:0] a,
                         input logic [31:0] d, input logic k, input logic c);
        logic err;
        logic go;
        @(negedge clk);
        check_bit("rsp_valid", exp_valid, rsp_valid);
        if (exp_valid && rsp_valid) begin
            check_data("rsp_data", exp_data, rsp_data);
        end
        check_bit("fault", exp_fault, fault);
        check_data("bad_addr", exp_bad, bad_addr);
        check_cnt("fault_cnt", exp_cnt, fault_cnt);
        req       = r;
        op        = o;
        addr      = a;
        rt_data   = d;
        kill      = k;
        fault_clr = c;
        err       = r && !k && bad_align(o, a[1:0]);
        go        = r && !k && !err;
        exp_valid = go && !ls_pkg::is_store(o);
        exp_fault = err;
        if (err) begin
            exp_bad = a;
            if (exp_cnt != '1) begin
                exp_cnt = exp_cnt + 1'b1;   // Saturates.
            end
        end else if (c) begin
            exp_bad = '0;
            exp_cnt = '0;
        end
        if (go && ls_pkg::is_store(o)) begin
            model_store(o, a, d);
        end else if (go) begin
            exp_data = model_load(o, a, d);
        end
    endtask

    task automatic idle();
        drive(1'b0, ls_pkg::LS_LW, 32'h0, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic read_sweep();
        for (int w = 0; w < DEPTH; w++) begin
            drive(1'b1, ls_pkg::LS_LW, w * 4, rand_bits(32), 1'b0, 1'b0);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        idle();
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err0);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_fill();
        int err0;
        err0 = errors;
        for (int w = 0; w < DEPTH; w++) begin
            drive(1'b1, ls_pkg::LS_SW, w * 4, rand_bits(32), 1'b0, 1'b0);
        end
        read_sweep();
        end_test("fill_readback", err0);
    endtask

    task automatic test_merge();
        int             err0;
        ls_pkg::ls_op_e o;
        logic [31:0]    a;
        ls_pkg::ls_op_e st_ops [4] = '{ls_pkg::LS_SB, ls_pkg::LS_SH,
                                       ls_pkg::LS_SWL, ls_pkg::LS_SWR};
        err0 = errors;
        for (int i = 0; i < N_MERGE; i++) begin
            o = st_ops[rand_bits(2)];
            a = rand_bits(ADDR_W + 2);
            if (o == ls_pkg::LS_SH) begin
                a[0] = 1'b0;
            end
            drive(1'b1, o, a, rand_bits(32), 1'b0, 1'b0);
            drive(1'b1, ls_pkg::LS_LW, {a[31:2], 2'b00}, rand_bits(32), 1'b0, 1'b0);
        end
        end_test("partial_stores", err0);
    endtask

    task automatic test_loads();
        int             err0;
        ls_pkg::ls_op_e o;
        logic [31:0]    a;
        ls_pkg::ls_op_e ld_ops [6] = '{ls_pkg::LS_LB, ls_pkg::LS_LBU, ls_pkg::LS_LH,
                                       ls_pkg::LS_LHU, ls_pkg::LS_LWL, ls_pkg::LS_LWR};
        err0 = errors;
        for (int i = 0; i < N_LOAD; i++) begin
            o = ld_ops[rand_bits(3) % 6];
            a = rand_bits(ADDR_W + 2);
            if (o == ls_pkg::LS_LH || o == ls_pkg::LS_LHU) begin
                a[0] = 1'b0;
            end
            drive(1'b1, o, a, rand_bits(32), 1'b0, 1'b0);
        end
        end_test("partial_loads", err0);
    endtask

    task automatic test_faults();
        int             err0;
        ls_pkg::ls_op_e o;
        logic [31:0]    a;
        ls_pkg::ls_op_e bad_ops [5] = '{ls_pkg::LS_LH, ls_pkg::LS_LHU, ls_pkg::LS_SH,
                                        ls_pkg::LS_LW, ls_pkg::LS_SW};
        err0 = errors;
        for (int i = 0; i < N_FAULT; i++) begin
            o = bad_ops[rand_bits(3) % 5];
            a = rand_bits(ADDR_W + 2);
            if (o == ls_pkg::LS_LW || o == ls_pkg::LS_SW) begin
                if (a[1:0] == 2'b00) begin
                    a[0] = 1'b1;
                end
            end else begin
                a[0] = 1'b1;
            end
            drive(1'b1, o, a, rand_bits(32), 1'b0, 1'b0);
        end
        check_cnt("fault_cnt", '1, fault_cnt);  // Counter pinned at its maximum.
        read_sweep();                           // Faulted stores must not write.
        end_test("address_errors", err0);
    endtask

    task automatic test_kill();
        int err0;
        err0 = errors;
        for (int i = 0; i < N_KILL; i++) begin
            drive(1'b1, ls_pkg::ls_op_e'(4'(rand_bits(4) % 12)), rand_bits(ADDR_W + 2),
                  rand_bits(32), 1'b1, 1'b0);
        end
        drive(1'b1, ls_pkg::LS_LW, 32'h0000_0006, 32'h0, 1'b0, 1'b1);
        drive(1'b0, ls_pkg::LS_LW, 32'h0, 32'h0, 1'b0, 1'b1);
        read_sweep();
        end_test("kill_and_clear", err0);
    endtask

    task automatic test_mixed();
        int err0;
        err0 = errors;
        for (int i = 0; i < N_MIX; i++) begin
            drive(rand_bits(3) != 0, ls_pkg::ls_op_e'(4'(rand_bits(4) % 12)),
                  rand_bits(ADDR_W + 2), rand_bits(32), rand_bits(3) == 0,
                  rand_bits(4) == 0);
        end
        end_test("mixed_stream", err0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        req          = 1'b0;
        op           = ls_pkg::LS_LW;
        addr         = '0;
        rt_data      = '0;
        kill         = 1'b0;
        fault_clr    = 1'b0;
        lfsr         = SEED;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_valid    = 1'b0;
        exp_data     = '0;
        exp_fault    = 1'b0;
        exp_bad      = '0;
        exp_cnt      = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        test_fill();
        test_merge();
        test_loads();
        test_faults();
        test_kill();
        test_mixed();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/ls_pkg.sv
verilog/addr_check.sv
verilog/mem_ctrl.sv
verilog/data_ram.sv
verilog/load_align.sv
verilog/lsu_top.sv
bench/lsu_asserts.sv
bench/lsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module lsu_tb

out=$(./obj_dir/Vlsu_tb 2>&1) || true
echo "$out"

if grep -q "TEST PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi

//--- verilog/addr_check.sv
`timescale 1ns/100ps
`default_nettype none

module addr_check #(
    parameter int FAULT_CNT_W = 8
) (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        req,
    input  wire ls_pkg::ls_op_e        op,
    input  wire [ls_pkg::DATA_W-1:0]   addr,
    input  wire                        kill,
    input  wire                        fault_clr,
    output logic                       addr_err,
    output logic                       fault,
    output logic [ls_pkg::DATA_W-1:0]  bad_addr,
    output logic [FAULT_CNT_W-1:0]     fault_cnt
);

    logic cnt_full;

    // A killed request never faults.
    assign addr_err = req & ~kill & ls_pkg::misaligned(op, addr[1:0]);
    assign cnt_full = &fault_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fault <= 1'b0;
        end else begin
            fault <= addr_err;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bad_addr <= '0;
        end else if (addr_err) begin
            bad_addr <= addr;                   // New fault beats a clear.
        end else if (fault_clr) begin
            bad_addr <= '0;
        end
    end

    // Saturating fault counter.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fault_cnt <= '0;
        end else if (addr_err) begin
            if (!cnt_full) begin
                fault_cnt <= fault_cnt + 1'b1;
            end
        end else if (fault_clr) begin
            fault_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
    parameter int ADDR_W = 8
) (
    input  wire                        clk,
    input  wire                        ram_en,
    input  wire [ls_pkg::BYTES-1:0]    ram_wen,
    input  wire [ADDR_W-1:0]           ram_addr,
    input  wire [ls_pkg::DATA_W-1:0]   ram_wdata,
    output logic [ls_pkg::DATA_W-1:0]  ram_rdata
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [ls_pkg::DATA_W-1:0] mem [DEPTH];
    logic                      rd_en;

    assign rd_en = ram_en & ~|ram_wen;  // Stores leave the read word alone.

    // Byte lane writes.
    always_ff @(posedge clk) begin
        if (ram_en) begin
            for (int i = 0; i < ls_pkg::BYTES; i++) begin
                if (ram_wen[i]) begin
                    mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/load_align.sv
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        ld_go,
    input  wire ls_pkg::ls_op_e        op,
    input  wire [1:0]                  addr_lo,
    input  wire [ls_pkg::DATA_W-1:0]   rt_data,
    input  wire [ls_pkg::DATA_W-1:0]   ram_rdata,
    output logic                       rsp_valid,
    output logic [ls_pkg::DATA_W-1:0]  rsp_data
);

    ls_pkg::ls_op_e            op_q;
    logic [1:0]                lo_q;
    logic [ls_pkg::DATA_W-1:0] rt_q;
    logic [7:0]                ld_byte;
    logic [15:0]               ld_half;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= ld_go;
        end
    end

    // Load context, lined up with the RAM read register.
    always_ff @(posedge clk) begin
        if (ld_go) begin
            op_q <= op;
            lo_q <= addr_lo;
            rt_q <= rt_data;
        end
    end

    assign ld_byte = ram_rdata[8*lo_q +: 8];
    assign ld_half = lo_q[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (op_q)
            ls_pkg::LS_LB: begin
                rsp_data = {{24{ld_byte[7]}}, ld_byte};
            end
            ls_pkg::LS_LBU: begin
                rsp_data = {24'b0, ld_byte};
            end
            ls_pkg::LS_LH: begin
                rsp_data = {{16{ld_half[15]}}, ld_half};
            end
            ls_pkg::LS_LHU: begin
                rsp_data = {16'b0, ld_half};
            end
            ls_pkg::LS_LWL: begin
                // Bytes at and below the offset fill the top of rt.
                case (lo_q)
                    2'b00:   rsp_data = {ram_rdata[7:0],  rt_q[23:0]};
                    2'b01:   rsp_data = {ram_rdata[15:0], rt_q[15:0]};
                    2'b10:   rsp_data = {ram_rdata[23:0], rt_q[7:0]};
                    default: rsp_data = ram_rdata;
                endcase
            end
            ls_pkg::LS_LWR: begin
                // Bytes at and above the offset fill the bottom of rt.
                case (lo_q)
                    2'b00:   rsp_data = ram_rdata;
                    2'b01:   rsp_data = {rt_q[31:24], ram_rdata[31:8]};
                    2'b10:   rsp_data = {rt_q[31:16], ram_rdata[31:16]};
                    default: rsp_data = {rt_q[31:8],  ram_rdata[31:24]};
                endcase
            end
            default: begin
                rsp_data = ram_rdata;           // LW.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/ls_pkg.sv
`default_nettype none

package ls_pkg;

    localparam int DATA_W = 32;
    localparam int BYTES  = DATA_W / 8;

    typedef enum logic [3:0] {
        LS_LB  = 4'd0,
        LS_LBU = 4'd1,
        LS_LH  = 4'd2,
        LS_LHU = 4'd3,
        LS_LW  = 4'd4,
        LS_LWL = 4'd5,
        LS_LWR = 4'd6,
        LS_SB  = 4'd7,
        LS_SH  = 4'd8,
        LS_SW  = 4'd9,
        LS_SWL = 4'd10,
        LS_SWR = 4'd11
    } ls_op_e;

    function automatic logic is_store(input ls_op_e op);
        return op inside {LS_SB, LS_SH, LS_SW, LS_SWL, LS_SWR};
    endfunction

    // Halfwords need an even address, words a zero low pair.
    // The unaligned word ops are exempt by design.
    function automatic logic misaligned(input ls_op_e op, input logic [1:0] addr_lo);
        logic bad;
        case (op)
            LS_LH, LS_LHU, LS_SH: begin
                bad = addr_lo[0];
            end
            LS_LW, LS_SW: begin
                bad = |addr_lo;
            end
            default: begin
                bad = 1'b0;
            end
        endcase
        return bad;
    endfunction

endpackage

`default_nettype wire

//--- verilog/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int ADDR_W      = 8,
    parameter int FAULT_CNT_W = 8
) (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        req,
    input  wire ls_pkg::ls_op_e        op,
    input  wire [ls_pkg::DATA_W-1:0]   addr,
    input  wire [ls_pkg::DATA_W-1:0]   rt_data,
    input  wire                        kill,
    input  wire                        fault_clr,
    output wire                        rsp_valid,
    output wire [ls_pkg::DATA_W-1:0]   rsp_data,
    output wire                        fault,
    output wire [ls_pkg::DATA_W-1:0]   bad_addr,
    output wire [FAULT_CNT_W-1:0]      fault_cnt
);

    wire                        addr_err;
    wire                        ram_en;
    wire [ls_pkg::BYTES-1:0]    ram_wen;
    wire [ADDR_W-1:0]           ram_addr;
    wire [ls_pkg::DATA_W-1:0]   ram_wdata;
    wire [ls_pkg::DATA_W-1:0]   ram_rdata;
    wire                        ld_go;

    addr_check #(
        .FAULT_CNT_W (FAULT_CNT_W)
    ) u_addr_check (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .kill        (kill),
        .fault_clr   (fault_clr),
        .addr_err    (addr_err),
        .fault       (fault),
        .bad_addr    (bad_addr),
        .fault_cnt   (fault_cnt)
    );

    mem_ctrl #(
        .ADDR_W      (ADDR_W)
    ) u_mem_ctrl (
        .req         (req),
        .op          (op),
        .addr        (addr),
        .rt_data     (rt_data),
        .kill        (kill),
        .addr_err    (addr_err),
        .ram_en      (ram_en),
        .ram_wen     (ram_wen),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ld_go       (ld_go)
    );

    data_ram #(
        .ADDR_W      (ADDR_W)
    ) u_data_ram (
        .clk         (clk),
        .ram_en      (ram_en),
        .ram_wen     (ram_wen),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata)
    );

    load_align u_load_align (
        .clk         (clk),
        .arst_n      (arst_n),
        .ld_go       (ld_go),
        .op          (op),
        .addr_lo     (addr[1:0]),
        .rt_data     (rt_data),
        .ram_rdata   (ram_rdata),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data)
    );

endmodule

`default_nettype wire

//--- verilog/mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl #(
    parameter int ADDR_W = 8
) (
    input  wire                        req,
    input  wire ls_pkg::ls_op_e        op,
    input  wire [ls_pkg::DATA_W-1:0]   addr,
    input  wire [ls_pkg::DATA_W-1:0]   rt_data,
    input  wire                        kill,
    input  wire                        addr_err,
    output logic                       ram_en,
    output logic [ls_pkg::BYTES-1:0]   ram_wen,
    output logic [ADDR_W-1:0]          ram_addr,
    output logic [ls_pkg::DATA_W-1:0]  ram_wdata,
    output logic                       ld_go
);

    logic [1:0]               lo;
    logic                     store;
    logic [ls_pkg::BYTES-1:0] lane_en;

    assign lo       = addr[1:0];
    assign store    = ls_pkg::is_store(op);
    assign ram_en   = req & ~kill & ~addr_err;
    assign ld_go    = ram_en & ~store;
    assign ram_wen  = {ls_pkg::BYTES{ram_en & store}} & lane_en;
    assign ram_addr = addr[ADDR_W+1:2];     // Word address.

    // Lane 0 holds the byte at offset 0.
    always_comb begin
        lane_en   = '0;
        ram_wdata = '0;
        case (op)
            ls_pkg::LS_SB: begin
                lane_en   = 4'b0001 << lo;
                ram_wdata = {4{rt_data[7:0]}};
            end
            ls_pkg::LS_SH: begin
                lane_en   = lo[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{rt_data[15:0]}};
            end
            ls_pkg::LS_SW: begin
                lane_en   = 4'b1111;
                ram_wdata = rt_data;
            end
            ls_pkg::LS_SWL: begin
                // High bytes of rt go to the lanes at and below the offset.
                case (lo)
                    2'b00: begin
                        lane_en   = 4'b0001;
                        ram_wdata = {24'b0, rt_data[31:24]};
                    end
                    2'b01: begin
                        lane_en   = 4'b0011;
                        ram_wdata = {16'b0, rt_data[31:16]};
                    end
                    2'b10: begin
                        lane_en   = 4'b0111;
                        ram_wdata = {8'b0, rt_data[31:8]};
                    end
                    default: begin
                        lane_en   = 4'b1111;
                        ram_wdata = rt_data;
                    end
                endcase
            end
            ls_pkg::LS_SWR: begin
                // Low bytes of rt go to the lanes at and above the offset.
                case (lo)
                    2'b00: begin
                        lane_en   = 4'b1111;
                        ram_wdata = rt_data;
                    end
                    2'b01: begin
                        lane_en   = 4'b1110;
                        ram_wdata = {rt_data[23:0], 8'b0};
                    end
                    2'b10: begin
                        lane_en   = 4'b1100;
                        ram_wdata = {rt_data[15:0], 16'b0};
                    end
                    default: begin
                        lane_en   = 4'b1000;
                        ram_wdata = {rt_data[7:0], 24'b0};
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire
